//--- build.f
design/hist_pkg.sv
design/wb_pkg.sv
design/chunk_byte_packer.sv
design/symbol_histogram.sv
design/wb_write_manager.sv
design/hist_capture_top.sv
tb/tb_sram_model.sv
tb/tb_hist_capture.sv

//--- design/chunk_byte_packer.sv
`timescale 1ns/100ps
module chunk_byte_packer (
  input  logic                       hwclk,
  input  logic                       reset,
  input  logic                       pulse_i,
  input  logic [hist_pkg::CHUNK_W-1:0] chunk_i,
  input  logic                       flush_i,
  output hist_pkg::byte_strobe_t     byte_o
);
  import hist_pkg::*;

  // at most 7 leftover bits plus one new chunk
  localparam int BUF_W = 2 * CHUNK_W;
  localparam int CNT_W = $clog2(BUF_W + 1);

  logic [BUF_W-1:0] held_q;
  logic [CNT_W-1:0] cnt_q;
  logic [BUF_W-1:0] merged;
  logic [CNT_W-1:0] merged_cnt;
  logic             full;
  logic             valid_q;
  symbol_t          symbol_q;

  // new chunk goes right above the bits already held
  assign merged = held_q | (BUF_W'(chunk_i) << cnt_q);
  assign merged_cnt = cnt_q + CNT_W'(CHUNK_W);
  assign full = merged_cnt >= CNT_W'(SYMBOL_W);

  always_ff @(posedge hwclk, posedge reset) begin
    if (reset) begin
      held_q <= '0;
      cnt_q <= '0;
      valid_q <= 1'b0;
    end else if (flush_i) begin
      held_q <= '0;
      cnt_q <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= pulse_i && full;
      if (pulse_i) begin
        if (full) begin
          // lsb first, so the low byte leaves and the rest moves down
          held_q <= merged >> SYMBOL_W;
          cnt_q <= merged_cnt - CNT_W'(SYMBOL_W);
        end else begin
          held_q <= merged;
          cnt_q <= merged_cnt;
        end
      end
    end
  end

  always_ff @(posedge hwclk) begin
    if (pulse_i) begin
      symbol_q <= merged[SYMBOL_W-1:0];
    end
  end

  assign byte_o = '{valid: valid_q, symbol: symbol_q};

endmodule

//--- design/hist_capture_top.sv
`timescale 1ns/100ps
module hist_capture_top #(
  parameter int                           COUNT_W   = $bits(hist_pkg::count_t),
  parameter logic [wb_pkg::WB_ADDR_W-1:0] BASE_ADDR = 32'h3000_0000
) (
  input  logic                         hwclk,
  input  logic                         reset,
  input  logic                         read_in_pulse_i,
  input  logic [hist_pkg::CHUNK_W-1:0] chunk_i,
  input  logic                         eof_i,
  output wb_pkg::wb_out_t              wb_o,
  input  logic                         wbs_ack_i,
  output logic                         done_o,
  output logic [31:0]                  total_o
);
  import hist_pkg::*;
  import wb_pkg::*;

  byte_strobe_t byte_s;
  wb_req_t      req_s;
  logic         busy_s;
  logic         flush_s;

  // 7-bit chunks in, bytes out
  chunk_byte_packer packer_i (
    .hwclk   (hwclk),
    .reset   (reset),
    .pulse_i (read_in_pulse_i),
    .chunk_i (chunk_i),
    .flush_i (flush_s),
    .byte_o  (byte_s)
  );

  symbol_histogram #(
    .COUNT_W   (COUNT_W),
    .BASE_ADDR (BASE_ADDR)
  ) histogram_i (
    .hwclk   (hwclk),
    .reset   (reset),
    .byte_i  (byte_s),
    .eof_i   (eof_i),
    .busy_i  (busy_s),
    .req_o   (req_s),
    .flush_o (flush_s),
    .done_o  (done_o),
    .total_o (total_o)
  );

  // one wishbone write per table entry
  wb_write_manager wb_mgr_i (
    .hwclk  (hwclk),
    .reset  (reset),
    .req_i  (req_s),
    .busy_o (busy_s),
    .wb_o   (wb_o),
    .ack_i  (wbs_ack_i)
  );

endmodule

//--- design/hist_pkg.sv
package hist_pkg;

  // byte symbols and the 256-entry table they index
  localparam int SYMBOL_W = 8;
  localparam int NUM_SYMBOLS = 1 << SYMBOL_W;

  // raw input chunk width
  localparam int CHUNK_W = 7;

  // default count width, the top takes its COUNT_W from count_t
  localparam int COUNT_DEF_W = 16;

  typedef logic [SYMBOL_W-1:0] symbol_t;

  typedef logic [COUNT_DEF_W-1:0] count_t;

  // one assembled byte, valid for a single cycle
  typedef struct packed {
    logic    valid;
    symbol_t symbol;
  } byte_strobe_t;

endpackage

//--- design/symbol_histogram.sv
`timescale 1ns/100ps
module symbol_histogram #(
  parameter int                              COUNT_W   = $bits(hist_pkg::count_t),
  parameter logic [wb_pkg::WB_ADDR_W-1:0]    BASE_ADDR = 32'h3000_0000
) (
  input  logic                   hwclk,
  input  logic                   reset,
  input  hist_pkg::byte_strobe_t byte_i,
  input  logic                   eof_i,
  input  logic                   busy_i,
  output wb_pkg::wb_req_t        req_o,
  output logic                   flush_o,
  output logic                   done_o,
  output logic [31:0]            total_o
);
  import hist_pkg::*;
  import wb_pkg::*;

  // count sits below the symbol byte in each dumped word
  localparam int FIELD_W = WB_DATA_W - SYMBOL_W;

  typedef enum logic [1:0] {
    ST_COUNT,
    ST_DRAIN,
    ST_DUMP
  } state_t;

  state_t               state_q;
  logic [COUNT_W-1:0]   table_q [NUM_SYMBOLS];
  logic [31:0]          total_cnt_q;
  logic [31:0]          total_q;
  symbol_t              idx_q;
  logic                 last_q;
  logic                 req_stb_q;
  logic [WB_ADDR_W-1:0] req_adr_q;
  logic [WB_DATA_W-1:0] req_dat_q;
  logic                 count_en;
  logic                 bus_free;
  logic                 issue;

  // drain catches the byte still inside the packer when eof arrives
  assign count_en = byte_i.valid && (state_q != ST_DUMP);

  // busy only rises a cycle after the strobe, so the strobe blocks too
  assign bus_free = !busy_i && !req_stb_q;
  assign issue = (state_q == ST_DUMP) && !last_q && bus_free;
  assign done_o = (state_q == ST_DUMP) && last_q && bus_free;

  assign flush_o = (state_q == ST_DUMP);

  // new total shows up together with done and is held afterwards
  assign total_o = done_o ? total_cnt_q : total_q;

  always_ff @(posedge hwclk, posedge reset) begin
    if (reset) begin
      for (int i = 0; i < NUM_SYMBOLS; i++) begin
        table_q[i] <= '0;
      end
    end else if (issue) begin
      // entry already latched into the request
      table_q[idx_q] <= '0;
    end else if (count_en) begin
      table_q[byte_i.symbol] <= table_q[byte_i.symbol] + 1'b1;
    end
  end

  always_ff @(posedge hwclk, posedge reset) begin
    if (reset) begin
      state_q <= ST_COUNT;
      idx_q <= '0;
      last_q <= 1'b0;
      req_stb_q <= 1'b0;
      total_cnt_q <= '0;
      total_q <= '0;
    end else begin
      req_stb_q <= issue;
      if (count_en) begin
        total_cnt_q <= total_cnt_q + 32'd1;
      end
      case (state_q)
        ST_COUNT: begin
          if (eof_i) begin
            state_q <= ST_DRAIN;
          end
        end
        ST_DRAIN: begin
          state_q <= ST_DUMP;
        end
        ST_DUMP: begin
          if (issue) begin
            // index wraps back to zero after the last entry
            idx_q <= idx_q + 1'b1;
            last_q <= (idx_q == '1);
          end
          if (done_o) begin
            state_q <= ST_COUNT;
            last_q <= 1'b0;
            total_q <= total_cnt_q;
            total_cnt_q <= '0;
          end
        end
        default: begin
          state_q <= ST_COUNT;
        end
      endcase
    end
  end

  always_ff @(posedge hwclk) begin
    if (issue) begin
      req_adr_q <= BASE_ADDR + (WB_ADDR_W'(idx_q) << 2);
      req_dat_q <= {idx_q, FIELD_W'(table_q[idx_q])};
    end
  end

  assign req_o = '{wr: req_stb_q, adr: req_adr_q, dat: req_dat_q};

endmodule

//--- design/wb_pkg.sv
package wb_pkg;

  localparam int WB_ADDR_W = 32;
  localparam int WB_DATA_W = 32;
  localparam int WB_SEL_W = WB_DATA_W / 8;

  // write request from the histogram, wr is a one-cycle strobe
  typedef struct packed {
    logic                 wr;
    logic [WB_ADDR_W-1:0] adr;
    logic [WB_DATA_W-1:0] dat;
  } wb_req_t;

  // wishbone manager outputs
  typedef struct packed {
    logic                 stb;
    logic                 cyc;
    logic                 we;
    logic [WB_SEL_W-1:0]  sel;
    logic [WB_ADDR_W-1:0] adr;
    logic [WB_DATA_W-1:0] dat;
  } wb_out_t;

endpackage

//--- design/wb_write_manager.sv
`timescale 1ns/100ps
module wb_write_manager (
  input  logic            hwclk,
  input  logic            reset,
  input  wb_pkg::wb_req_t req_i,
  output logic            busy_o,
  output wb_pkg::wb_out_t wb_o,
  input  logic            ack_i
);
  import wb_pkg::*;

  logic                 active_q;
  logic [WB_ADDR_W-1:0] adr_q;
  logic [WB_DATA_W-1:0] dat_q;
  logic                 start;
  logic                 finish;

  // requests while a cycle is open are not taken
  assign start = req_i.wr && !active_q;
  assign finish = active_q && ack_i;

  always_ff @(posedge hwclk, posedge reset) begin
    if (reset) begin
      active_q <= 1'b0;
    end else if (start) begin
      active_q <= 1'b1;
    end else if (finish) begin
      // cycle closes right after the ack
      active_q <= 1'b0;
    end
  end

  // address and data held stable for the whole cycle
  always_ff @(posedge hwclk) begin
    if (start) begin
      adr_q <= req_i.adr;
      dat_q <= req_i.dat;
    end
  end

  assign busy_o = active_q;

  // write only, so we follows stb and cyc
  assign wb_o = '{
    stb: active_q,
    cyc: active_q,
    we:  active_q,
    sel: {WB_SEL_W{1'b1}},
    adr: adr_q,
    dat: dat_q
  };

endmodule

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_hist_capture \
  -f build.f -o tb_hist_capture > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_hist_capture > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q '^>>> PASS$' "$SIM_LOG"; then
  exit 0
fi
echo "pass line not found in $SIM_LOG"
exit 1

//--- tb/tb_hist_capture.sv
`timescale 1ns/100ps
module tb_hist_capture;
  import hist_pkg::*;
  import wb_pkg::*;

  localparam logic [31:0] BASE_ADDR = 32'h3000_0000;
  localparam int NUM_FILES = 5;
  localparam int MAX_CHUNKS = 12;

  // one row per file: chunk count, expected byte total, chunks, idle gaps
  localparam int FILE_LEN [NUM_FILES] = '{8, 7, 12, 3, 1};
  localparam int FILE_TOTAL [NUM_FILES] = '{7, 6, 10, 2, 0};
  localparam logic [6:0] FILE_CHUNK [NUM_FILES][MAX_CHUNKS] = '{
    '{7'h01, 7'h02, 7'h04, 7'h08, 7'h10, 7'h20, 7'h40, 7'h7f, 7'h00, 7'h00, 7'h00, 7'h00},
    '{7'h7f, 7'h7f, 7'h7f, 7'h7f, 7'h7f, 7'h7f, 7'h7f, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00},
    '{7'h55, 7'h2a, 7'h55, 7'h2a, 7'h55, 7'h2a, 7'h55, 7'h2a, 7'h55, 7'h2a, 7'h55, 7'h2a},
    '{7'h13, 7'h6e, 7'h35, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00},
    '{7'h7f, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00}
  };
  localparam int FILE_GAP [NUM_FILES][MAX_CHUNKS] = '{
    '{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0},
    '{1, 0, 2, 0, 3, 0, 1, 0, 0, 0, 0, 0},
    '{0, 3, 0, 0, 1, 0, 2, 0, 0, 3, 0, 1},
    '{2, 2, 2, 0, 0, 0, 0, 0, 0, 0, 0, 0},
    '{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0}
  };

  function automatic int chunk_sum();
    int n;
    n = 0;
    for (int f = 0; f < NUM_FILES; f++) begin
      n += FILE_LEN[f];
    end
    return n;
  endfunction

  // a dump takes up to 6 cycles per entry with the slowest ack
  localparam int CYCLE_LIMIT = NUM_FILES * 300 * 8 + chunk_sum() * 20;

  logic               hwclk;
  logic               reset;
  logic               read_in_pulse;
  logic [CHUNK_W-1:0] chunk;
  logic               eof;
  wb_out_t            wb;
  logic               ack;
  logic               done;
  logic [31:0]        total;
  count_t             exp_count [NUM_SYMBOLS];
  int unsigned        cycles = 0;

  hist_capture_top #(
    .COUNT_W   ($bits(count_t)),
    .BASE_ADDR (BASE_ADDR)
  ) dut_i (
    .hwclk           (hwclk),
    .reset           (reset),
    .read_in_pulse_i (read_in_pulse),
    .chunk_i         (chunk),
    .eof_i           (eof),
    .wb_o            (wb),
    .wbs_ack_i       (ack),
    .done_o          (done),
    .total_o         (total)
  );

  tb_sram_model #(
    .BASE_ADDR (BASE_ADDR)
  ) sram_i (
    .hwclk (hwclk),
    .reset (reset),
    .wb_i  (wb),
    .ack_o (ack)
  );

  initial begin
    hwclk = 1'b0;
    forever #2 hwclk = ~hwclk;
  end

  always @(posedge hwclk) begin
    cycles <= cycles + 1;
    if (cycles >= 32'(CYCLE_LIMIT)) begin
      $display("timeout: no done pulse within %0d cycles", CYCLE_LIMIT);
      $display(">>> FAIL");
      $fatal(1);
    end
  end

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    $display(">>> FAIL");
    $fatal(1);
  endtask

  task automatic check_count(input string name, input count_t got, input count_t exp);
    if (got !== exp) report_mismatch(name, 32'(got), 32'(exp));
  endtask

  task automatic check_symbol(input string name, input symbol_t got, input symbol_t exp);
    if (got !== exp) report_mismatch(name, 32'(got), 32'(exp));
  endtask

  task automatic check_total(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) report_mismatch(name, got, exp);
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) report_mismatch(name, 32'(got), 32'(exp));
  endtask

  // expected table, chunks packed lsb first, leftover bits dropped
  task automatic model_file(input int f);
    logic [15:0] acc;
    int          nbits;
    acc = '0;
    nbits = 0;
    for (int s = 0; s < NUM_SYMBOLS; s++) begin
      exp_count[s] = '0;
    end
    for (int i = 0; i < FILE_LEN[f]; i++) begin
      acc = acc | (16'(FILE_CHUNK[f][i]) << nbits);
      nbits += CHUNK_W;
      if (nbits >= SYMBOL_W) begin
        exp_count[acc[7:0]] = exp_count[acc[7:0]] + count_t'(1);
        acc = acc >> SYMBOL_W;
        nbits -= SYMBOL_W;
      end
    end
  endtask

  task automatic send_chunk(input logic [6:0] c, input int gap);
    read_in_pulse = 1'b1;
    chunk = c;
    @(negedge hwclk);
    read_in_pulse = 1'b0;
    repeat (gap) @(negedge hwclk);
  endtask

  // stray pulses and eof during the dump, until done shows up
  task automatic wait_dump_end();
    int n;
    n = 0;
    while (!done) begin
      read_in_pulse = n[0];
      chunk = 7'(n * 37);
      eof = (n % 5 == 4);
      n++;
      @(negedge hwclk);
    end
    read_in_pulse = 1'b0;
    eof = 1'b0;
  endtask

  task automatic check_file(input int f);
    logic [31:0] word;
    check_total("total_o", total, 32'(FILE_TOTAL[f]));
    for (int s = 0; s < NUM_SYMBOLS; s++) begin
      word = sram_i.mem[s];
      check_total($sformatf("sram writes[%02h]", s), sram_i.writes[s], 32'(f + 1));
      check_symbol($sformatf("sram symbol[%02h]", s), word[31:24], symbol_t'(s));
      check_total($sformatf("sram pad[%02h]", s), 32'(word[23:$bits(count_t)]), '0);
      check_count($sformatf("sram count[%02h]", s), word[$bits(count_t)-1:0], exp_count[s]);
    end
  endtask

  initial begin
    reset = 1'b1;
    read_in_pulse = 1'b0;
    chunk = '0;
    eof = 1'b0;
    repeat (2) @(negedge hwclk);
    reset = 1'b0;
    @(negedge hwclk);
    check_bit("wb_o.stb", wb.stb, 1'b0);
    check_bit("wb_o.cyc", wb.cyc, 1'b0);
    check_bit("done_o", done, 1'b0);
    check_total("total_o", total, '0);

    for (int f = 0; f < NUM_FILES; f++) begin
      model_file(f);
      for (int i = 0; i < FILE_LEN[f]; i++) begin
        send_chunk(FILE_CHUNK[f][i], FILE_GAP[f][i]);
      end
      eof = 1'b1;
      @(negedge hwclk);
      eof = 1'b0;
      @(negedge hwclk);
      wait_dump_end();
      check_file(f);
      // back in the count state after this edge
      @(negedge hwclk);
    end

    check_total("sram bad writes", sram_i.bad_writes, '0);
    $display(">>> PASS");
    $finish;
  end

endmodule

//--- tb/tb_sram_model.sv
`timescale 1ns/100ps
module tb_sram_model #(
  parameter logic [31:0] BASE_ADDR = 32'h3000_0000
) (
  input  logic            hwclk,
  input  logic            reset,
  input  wb_pkg::wb_out_t wb_i,
  output logic            ack_o
);
  import hist_pkg::*;
  import wb_pkg::*;

  logic [WB_DATA_W-1:0] mem [NUM_SYMBOLS];
  int unsigned          writes [NUM_SYMBOLS];
  int unsigned          bad_writes;
  logic [15:0]          lfsr_q;
  logic [1:0]           delay_q;
  logic [1:0]           wait_q;
  logic                 ack_q = 1'b0;
  logic [31:0]          offset;

  // 16-bit fibonacci lfsr, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  assign offset = wb_i.adr - BASE_ADDR;
  assign ack_o = ack_q;

  // runs on the falling edge, bus outputs are stable here
  always @(negedge hwclk) begin : slave
    logic [15:0] s;
    s = lfsr_q;
    if (reset) begin
      ack_q <= 1'b0;
      wait_q <= '0;
      delay_q <= '0;
      lfsr_q <= 16'd60983;
      bad_writes <= 0;
      for (int i = 0; i < NUM_SYMBOLS; i++) begin
        mem[i] <= '0;
        writes[i] <= 0;
      end
    end else if (ack_q) begin
      // the rising edge in between has closed the cycle
      ack_q <= 1'b0;
    end else if (wb_i.stb && wb_i.cyc) begin
      if (wait_q == delay_q) begin
        if (!wb_i.we || wb_i.sel != '1 || offset[1:0] != 2'b00 ||
            offset >= 32'(4 * NUM_SYMBOLS)) begin
          bad_writes <= bad_writes + 1;
        end else begin
          mem[offset[9:2]] <= wb_i.dat;
          writes[offset[9:2]] <= writes[offset[9:2]] + 1;
        end
        ack_q <= 1'b1;
        wait_q <= '0;
        // two fresh bits for the next ack delay
        s = lfsr_next(s);
        delay_q[0] <= s[0];
        s = lfsr_next(s);
        delay_q[1] <= s[0];
        lfsr_q <= s;
      end else begin
        wait_q <= wait_q + 2'd1;
      end
    end
  end

endmodule
